// ==== pcs_tx_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Encoder checker, bound into every pcs_tx_encoder
// Reset, code-group weight and disparity flip properties
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pcs_tx_checker
    import pcs_tx_pkg::*;
(
    input logic            clk,
    input logic            rst,
    input cg_req_t         req,
    input logic            rd_pos,
    input logic [cg_w-1:0] tx_code_group,
    input logic            tx_oset_indicate
);

    // No set end is flagged while in reset
    assert property (@(posedge clk) !rst |=> !tx_oset_indicate)
    else $error("tx_oset_indicate high during reset");

    // Valid 8b/10b groups carry 4, 5 or 6 ones
    assert property (@(posedge clk) rst && req.emit |=>
                     ($countones(tx_code_group) >= 4 && $countones(tx_code_group) <= 6))
    else $error("Emitted code group has a bad number of ones");

    // Unbalanced group flips the running disparity
    assert property (@(posedge clk) rst && req.emit |=>
                     ($countones(tx_code_group) == 5 || rd_pos != $past(rd_pos)))
    else $error("Unbalanced code group left rd_pos unchanged");

endmodule

bind pcs_tx_encoder pcs_tx_checker pcs_tx_checker_i (.*);

`default_nettype wire

// ==== pcs_tx_code_group.sv ====
//////////////////////////////////////////////////////////////////////
// PCS transmit code-group stage
// Decoder, ordered-set sequencer and 8b/10b encoder
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pcs_tx_code_group
    import pcs_tx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              power_on,
    input  logic [oset_w-1:0] tx_o_set,
    input  logic [oset_w-1:0] data_o_set,
    output logic [cg_w-1:0]   tx_code_group,
    output logic              tx_oset_indicate
);

    req_kind_t  kind;
    logic [3:0] digit;
    cg_req_t    req;
    logic       rd_pos; // Encoder disparity back to the sequencer

    pcs_tx_oset_decode pcs_tx_oset_decode_i (
        .tx_o_set   (tx_o_set),
        .data_o_set (data_o_set),
        .power_on   (power_on),
        .kind       (kind),
        .digit      (digit)
    );

    pcs_tx_sequencer pcs_tx_sequencer_i (
        .clk    (clk),
        .rst    (rst),
        .kind   (kind),
        .digit  (digit),
        .oset   (tx_o_set),
        .rd_pos (rd_pos),
        .req    (req)
    );

    pcs_tx_encoder pcs_tx_encoder_i (
        .clk              (clk),
        .rst              (rst),
        .req              (req),
        .rd_pos           (rd_pos),
        .tx_code_group    (tx_code_group),
        .tx_oset_indicate (tx_oset_indicate)
    );

endmodule

`default_nettype wire

// ==== pcs_tx_encoder.sv ====
//////////////////////////////////////////////////////////////////////
// 8b/10b code-group encoder
// Looks up the group in the column of the current disparity,
// registers the outputs and keeps the running disparity
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pcs_tx_encoder
    import pcs_tx_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  cg_req_t         req,
    output logic            rd_pos,           // 1 means positive
    output logic [cg_w-1:0] tx_code_group,
    output logic            tx_oset_indicate
);

    cg_pair_t        pair;
    logic [cg_w-1:0] group;
    logic            rd_after;

    //////////////////////////////////////////////////////////////////////
    // Table lookup
    always_comb
    begin
        pair     = code_table(req.sym, req.digit);
        group    = rd_pos ? pair.pos : pair.neg;
        rd_after = rd_next(group, rd_pos);
    end

    //////////////////////////////////////////////////////////////////////
    // Output and disparity registers
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            tx_code_group    <= '0;
            tx_oset_indicate <= 1'b0;
            rd_pos           <= 1'b0; // Start at RD-
        end
        else
        begin
            tx_oset_indicate <= req.emit & req.last; // One pulse per set end
            if (req.emit)
            begin
                tx_code_group <= group;
                rd_pos        <= rd_after;
            end
            // No emission holds group and disparity
        end
    end

endmodule

`default_nettype wire

// ==== pcs_tx_oset_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Ordered-set request decoder
// Sorts tx_o_set and the data byte into one request kind
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pcs_tx_oset_decode
    import pcs_tx_pkg::*;
(
    input  logic [oset_w-1:0] tx_o_set,
    input  logic [oset_w-1:0] data_o_set,
    input  logic              power_on,
    output req_kind_t         kind,
    output logic [3:0]        digit
);

    always_comb
    begin
        kind = req_none;
        if (power_on)
        begin
            case (tx_o_set)
                oset_idle: kind = req_idle;
                oset_data:
                begin
                    // Only D0 to D9 are in the table
                    if (data_o_set <= data_max)
                        kind = req_data;
                end
                oset_start,
                oset_end,
                oset_ext:  kind = req_special;
                default:   kind = req_none; // Unknown code
            endcase
        end
    end

    assign digit = data_o_set[3:0]; // Meaningful only with req_data

endmodule

`default_nettype wire

// ==== pcs_tx_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// PCS transmit code-group package
// Widths, ordered-set request codes, symbol and request types,
// the 8b/10b table for the supported characters and the running
// disparity rule shared by the transmit blocks
//////////////////////////////////////////////////////////////////////
`default_nettype none

package pcs_tx_pkg;

    localparam int oset_w = 8;  // Ordered-set request and data byte
    localparam int cg_w   = 10; // One 8b/10b code group, abcdei fghj

    // Request codes on tx_o_set
    localparam logic [oset_w-1:0] oset_idle  = 8'b10111100;
    localparam logic [oset_w-1:0] oset_data  = 8'b11111111;
    localparam logic [oset_w-1:0] oset_start = 8'b11111011;
    localparam logic [oset_w-1:0] oset_end   = 8'b11111101;
    localparam logic [oset_w-1:0] oset_ext   = 8'b11110111;

    localparam logic [oset_w-1:0] data_max = 8'd9; // Highest data byte, D9.0

    typedef enum logic [1:0] {
        req_none,
        req_idle,
        req_data,
        req_special
    } req_kind_t;

    // T is named sym_term since sym_t is the type itself
    typedef enum logic [3:0] {
        sym_k28_5,  // Comma, first group of an idle
        sym_d5_6,   // I1 second group
        sym_d16_2,  // I2 second group
        sym_s,      // K27.7 start of packet
        sym_term,   // K29.7 end of packet
        sym_r,      // K23.7 carrier extend
        sym_data    // D0.0 to D9.0, value in digit
    } sym_t;

    typedef struct packed {
        logic       emit;  // A group goes out this cycle
        sym_t       sym;
        logic [3:0] digit; // Data value 0 to 9
        logic       last;  // Group ends an ordered set
    } cg_req_t;

    typedef struct packed {
        logic [cg_w-1:0] neg; // RD- column
        logic [cg_w-1:0] pos; // RD+ column
    } cg_pair_t;

    //////////////////////////////////////////////////////////////////////
    // Code groups, bit 9 is a and bit 0 is j
    function automatic cg_pair_t code_table(input sym_t sym, input logic [3:0] digit);
        cg_pair_t pair;
        pair = '0;
        case (sym)
            sym_k28_5: pair = '{neg: 10'b0011111010, pos: 10'b1100000101};
            sym_d5_6:  pair = '{neg: 10'b1010010110, pos: 10'b1010010110};
            sym_d16_2: pair = '{neg: 10'b0110110101, pos: 10'b1001000101};
            sym_s:     pair = '{neg: 10'b1101101000, pos: 10'b0010010111};
            sym_term:  pair = '{neg: 10'b1011101000, pos: 10'b0100010111};
            sym_r:     pair = '{neg: 10'b1110101000, pos: 10'b0001010111};
            sym_data:
            begin
                case (digit)
                    4'd0: pair = '{neg: 10'b1001110100, pos: 10'b0110001011};
                    4'd1: pair = '{neg: 10'b0111010100, pos: 10'b1000101011};
                    4'd2: pair = '{neg: 10'b1011010100, pos: 10'b0100101011};
                    4'd3: pair = '{neg: 10'b1100011011, pos: 10'b1100010100};
                    4'd4: pair = '{neg: 10'b1101010100, pos: 10'b0010101011};
                    4'd5: pair = '{neg: 10'b1010011011, pos: 10'b1010010100};
                    4'd6: pair = '{neg: 10'b0110011011, pos: 10'b0110010100};
                    4'd7: pair = '{neg: 10'b1110001011, pos: 10'b0001110100};
                    4'd8: pair = '{neg: 10'b1110010100, pos: 10'b0001101011};
                    4'd9: pair = '{neg: 10'b1001011011, pos: 10'b1001010100};
                    default: pair = '0;
                endcase
            end
            default: pair = '0;
        endcase
        return pair;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Running disparity after one group, 6b sub-block then 4b sub-block
    function automatic logic rd_next(input logic [cg_w-1:0] cg, input logic rd);
        logic [5:0] sb6;
        logic [3:0] sb4;
        logic [2:0] ones6;
        logic [2:0] ones4;
        logic       rd_mid;
        logic       rd_out;
        sb6   = cg[9:4];
        sb4   = cg[3:0];
        ones6 = '0;
        ones4 = '0;
        for (int i = 0; i < 6; i++)
            ones6 = ones6 + 3'(sb6[i]);
        for (int i = 0; i < 4; i++)
            ones4 = ones4 + 3'(sb4[i]);

        if (ones6 > 3'd3 || sb6 == 6'b000111)
            rd_mid = 1'b1;
        else if (ones6 < 3'd3 || sb6 == 6'b111000)
            rd_mid = 1'b0;
        else
            rd_mid = rd; // Neutral block keeps the disparity

        if (ones4 > 3'd2 || sb4 == 4'b0011)
            rd_out = 1'b1;
        else if (ones4 < 3'd2 || sb4 == 4'b1100)
            rd_out = 1'b0;
        else
            rd_out = rd_mid;
        return rd_out;
    endfunction

endpackage

`default_nettype wire

// ==== pcs_tx_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// Ordered-set sequencer
// Picks the symbol for each cycle; an idle takes two cycles,
// data and special groups take one
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pcs_tx_sequencer
    import pcs_tx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  req_kind_t         kind,
    input  logic [3:0]        digit,
    input  logic [oset_w-1:0] oset,   // Tells S, T and R apart
    input  logic              rd_pos, // Disparity after the last group
    output cg_req_t           req
);

    typedef enum logic {
        st_ready,
        st_idle_second
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= st_ready;
        else
            state <= state_nxt;
    end

    //////////////////////////////////////////////////////////////////////
    // Symbol selection
    always_comb
    begin
        state_nxt = state;
        req.emit  = 1'b0;
        req.sym   = sym_k28_5;
        req.digit = '0;
        req.last  = 1'b0;

        case (state)
            st_ready:
            begin
                case (kind)
                    req_idle:
                    begin
                        req.emit  = 1'b1; // Comma first, set not done yet
                        req.sym   = sym_k28_5;
                        state_nxt = st_idle_second;
                    end
                    req_data:
                    begin
                        req.emit  = 1'b1;
                        req.sym   = sym_data;
                        req.digit = digit;
                        req.last  = 1'b1;
                    end
                    req_special:
                    begin
                        req.emit = 1'b1;
                        req.last = 1'b1;
                        case (oset)
                            oset_start: req.sym = sym_s;
                            oset_end:   req.sym = sym_term;
                            default:    req.sym = sym_r;
                        endcase
                    end
                    default: req.emit = 1'b0; // Nothing to send
                endcase
            end

            st_idle_second:
            begin
                // rd_pos is already past K28.5, so it is the inverse of the
                // disparity at the start of the set. Positive here means
                // the set began negative, which calls for I2
                req.emit  = 1'b1;
                req.sym   = rd_pos ? sym_d16_2 : sym_d5_6;
                req.last  = 1'b1;
                state_nxt = st_ready; // Request in this cycle is dropped
            end

            default: state_nxt = st_ready;
        endcase
    end

endmodule

`default_nettype wire

// ==== tb_pcs_tx.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the PCS transmit code-group stage
// LFSR stimulus, reference model of the ordered-set rules and
// a compare process on tx_code_group and tx_oset_indicate
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_pcs_tx
    import pcs_tx_pkg::*;
();

    logic              clk;
    logic              rst;
    logic              power_on;
    logic [oset_w-1:0] tx_o_set;
    logic [oset_w-1:0] data_o_set;
    logic [cg_w-1:0]   tx_code_group;
    logic              tx_oset_indicate;

    logic [31:0]       lfsr_state;
    logic              ref_second;  // Second group of an idle is due
    logic              ref_rd;      // Expected disparity with 1 as positive
    logic [cg_w-1:0]   exp_group;
    logic              exp_ind;
    int                group_errors;
    int                indicate_errors;
    int                cycle_cnt;
    int                cycle_limit;

    pcs_tx_code_group pcs_tx_code_group_i (
        .clk              (clk),
        .rst              (rst),
        .power_on         (power_on),
        .tx_o_set         (tx_o_set),
        .data_o_set       (data_o_set),
        .tx_code_group    (tx_code_group),
        .tx_oset_indicate (tx_oset_indicate)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // 32-bit Galois LFSR as random source
    function logic next_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'h80200003;
        return out;
    endfunction

    function logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[6:0], next_bit()};
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model stepped once per rising edge
    function void ref_step(input logic rst_s, input logic [7:0] oset,
                           input logic [7:0] data, input logic pwr);
        cg_pair_t pair;
        logic     send;
        logic     ends;
        sym_t     sym;
        send = 1'b0;
        ends = 1'b0;
        sym  = sym_k28_5;
        if (!rst_s)
        begin
            ref_second = 1'b0;
            ref_rd     = 1'b0;
            exp_group  = '0;
            exp_ind    = 1'b0;
        end
        else
        begin
            if (ref_second)
            begin
                // K28.5 left RD positive only if the set began at RD- and needs I2
                send       = 1'b1;
                ends       = 1'b1;
                sym        = ref_rd ? sym_d16_2 : sym_d5_6;
                ref_second = 1'b0;
            end
            else if (pwr)
            begin
                send = 1'b1;
                ends = 1'b1;
                if (oset == oset_idle)
                begin
                    ends       = 1'b0;
                    ref_second = 1'b1;
                end
                else if (oset == oset_data && data <= 8'd9)
                    sym = sym_data;
                else if (oset == oset_start)
                    sym = sym_s;
                else if (oset == oset_end)
                    sym = sym_term;
                else if (oset == oset_ext)
                    sym = sym_r;
                else
                begin
                    send = 1'b0; // Unknown code or byte above 9
                    ends = 1'b0;
                end
            end
            exp_ind = ends;
            if (send)
            begin
                pair      = code_table(sym, data[3:0]);
                exp_group = ref_rd ? pair.pos : pair.neg;
                ref_rd    = rd_next(exp_group, ref_rd);
            end
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks that hold values from 2 ns after one edge to the next
    task apply_req(input logic [7:0] oset, input logic [7:0] data, input logic pwr);
        tx_o_set   = oset;
        data_o_set = data;
        power_on   = pwr;
        @(posedge clk);
        #2;
    endtask

    task random_data();
        logic [7:0] val;
        val = take_bits(4);
        apply_req(oset_data, val % 10, 1'b1);
    endtask

    task random_special();
        logic [7:0] sel;
        sel = take_bits(2);
        case (sel)
            8'd0:    apply_req(oset_start, 8'h00, 1'b1);
            8'd1:    apply_req(oset_end, 8'h00, 1'b1);
            default: apply_req(oset_ext, 8'h00, 1'b1);
        endcase
    endtask

    task random_mix();
        logic [7:0] pick;
        logic [7:0] val;
        pick = take_bits(3);
        val  = take_bits(4);
        case (pick)
            8'd3:    apply_req(oset_idle, val, 1'b1);
            8'd4:    random_special();
            8'd5:    apply_req(8'h55, val, 1'b1);            // Unknown code
            8'd6:    apply_req(oset_data, val % 10, 1'b0);   // Power off
            8'd7:    apply_req(oset_data, 8'd10 + val, 1'b1); // Byte above 9
            default: apply_req(oset_data, val % 10, 1'b1);
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare process sampling inputs at the edge and outputs 1 ns later
    initial
    begin
        group_errors    = 0;
        indicate_errors = 0;
        forever
        begin
            @(posedge clk);
            ref_step(rst, tx_o_set, data_o_set, power_on);
            #1;
            assert (tx_code_group === exp_group)
            else
            begin
                group_errors++;
                $display("Error at %0t ns: tx_code_group is %b, expected %b",
                         $time, tx_code_group, exp_group);
            end
            assert (tx_oset_indicate === exp_ind)
            else
            begin
                indicate_errors++;
                $display("Error at %0t ns: tx_oset_indicate is %b, expected %b",
                         $time, tx_oset_indicate, exp_ind);
            end
        end
    end

    initial
    begin
        cycle_cnt   = 0;
        cycle_limit = 800; // About 600 stimulus cycles plus margin
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the stimulus did not finish within %0d cycles", cycle_limit);
        $display("Counts: %0d group errors, %0d indicate errors",
                 group_errors, indicate_errors);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial
    begin
        rst        = 1'b0;
        power_on   = 1'b1;      // Data request held through reset
        tx_o_set   = oset_data;
        data_o_set = 8'd7;
        lfsr_state = 32'd95923;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b1;

        apply_req(8'h00, 8'h00, 1'b1);  // Output stays zero
        apply_req(8'h00, 8'h00, 1'b1);
        apply_req(oset_idle, 8'h00, 1'b1); // Idle from RD-
        apply_req(oset_data, 8'd3, 1'b1);  // Dropped during second group
        apply_req(oset_data, 8'd3, 1'b1);  // D3.0 turns RD positive
        apply_req(oset_idle, 8'h00, 1'b1); // Idle from RD+
        apply_req(oset_start, 8'h00, 1'b1); // Dropped during second group

        repeat (150) random_data();
        repeat (60) random_special();

        apply_req(oset_data, 8'd3, 1'b1);
        apply_req(oset_idle, 8'h00, 1'b0);  // Power off
        apply_req(8'h42, 8'h00, 1'b1);
        apply_req(oset_data, 8'd12, 1'b1);
        apply_req(oset_data, 8'd0, 1'b1);   // Column from held disparity

        repeat (300) random_mix();
        apply_req(8'h00, 8'h00, 1'b1);
        apply_req(8'h00, 8'h00, 1'b1);

        $display("Finished after %0d cycles: %0d group errors, %0d indicate errors",
                 cycle_cnt, group_errors, indicate_errors);
        if (group_errors == 0 && indicate_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
pcs_tx_pkg.sv
pcs_tx_oset_decode.sv
pcs_tx_sequencer.sv
pcs_tx_encoder.sv
pcs_tx_code_group.sv
pcs_tx_checker.sv
tb_pcs_tx.sv
